// File: id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// ====================
// datapath and register file sizing
// ====================
`define ID_XLEN     32
`define ID_NREGS    32
`define ID_RIDX_W   5

// fetch restarts here after reset or flush
`define ID_RESET_PC 32'h8000_0000

`endif

// File: id_pkg.sv
`default_nettype none

`include "id_defs.svh"

package id_pkg;

    // rv32i major opcodes, low two bits included
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
    } alu_op_e;

    // nine memory ops, needs four bits
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE} imm_type_e;
    typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_e;
    typedef enum logic       {OPB_REG, OPB_IMM} op_b_sel_e;

    // ====================
    // bundles
    // ====================
    typedef struct packed {
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        imm_type_e imm_type;
        mem_op_e   mem_op;
        logic      rd_we;
        logic      is_branch;  // b-type only
        logic      is_jal;
        logic      is_jalr;
        logic      illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic                  we;
        logic [`ID_RIDX_W-1:0] rd;
        logic [`ID_XLEN-1:0]   data;
    } wb_port_t;

    typedef struct packed {
        logic                valid;
        logic [`ID_XLEN-1:0] pc;
    } ex_redirect_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [`ID_XLEN-1:0]   op_a;
        logic [`ID_XLEN-1:0]   op_b;
        logic [`ID_XLEN-1:0]   rs2_val;   // store data, branch compare
        logic [`ID_XLEN-1:0]   imm;
        logic [`ID_RIDX_W-1:0] rd;
        logic                  rd_we;
        mem_op_e               mem_op;
        logic                  is_branch;
        logic                  is_jalr;
        logic                  pred_taken;
        logic [`ID_XLEN-1:0]   pred_pc;
        logic [`ID_XLEN-1:0]   pc_next;   // link value, fall-through
        logic                  illegal;
    } id_ex_t;

endpackage

`default_nettype wire

// File: id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
    input  logic [31:0] instr_i,
    output dec_ctrl_t   ctrl_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // shared by op and op-imm, alt picks sub / sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_a_sel = OPA_REG;
        ctrl_o.op_b_sel = OPB_REG;
        ctrl_o.imm_type = IMM_NONE;
        ctrl_o.mem_op   = MEM_NONE;

        case (opcode)
            OPC_OP: begin
                ctrl_o.rd_we  = 1'b1;
                ctrl_o.alu_op = arith_op(funct3, funct7[5]);
                if (funct7 == 7'b0100000) begin
                    ctrl_o.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                end else begin
                    ctrl_o.illegal = (funct7 != 7'b0000000);
                end
            end
            OPC_OP_IMM: begin
                ctrl_o.rd_we    = 1'b1;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.imm_type = IMM_I;
                ctrl_o.alu_op   = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) begin
                    ctrl_o.illegal = (funct7 != 7'b0000000);   // slli
                end else if (funct3 == 3'b101) begin
                    ctrl_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl_o.rd_we    = 1'b1;
                ctrl_o.op_a_sel = (opcode == OPC_LUI) ? OPA_ZERO : OPA_PC;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.imm_type = IMM_U;
            end
            OPC_LOAD: begin
                ctrl_o.rd_we    = 1'b1;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.imm_type = IMM_I;
                case (funct3)
                    3'b000:  ctrl_o.mem_op = MEM_LB;
                    3'b001:  ctrl_o.mem_op = MEM_LH;
                    3'b010:  ctrl_o.mem_op = MEM_LW;
                    3'b100:  ctrl_o.mem_op = MEM_LBU;
                    3'b101:  ctrl_o.mem_op = MEM_LHU;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                ctrl_o.op_b_sel = OPB_IMM;   // address = rs1 + imm
                ctrl_o.imm_type = IMM_S;
                case (funct3)
                    3'b000:  ctrl_o.mem_op = MEM_SB;
                    3'b001:  ctrl_o.mem_op = MEM_SH;
                    3'b010:  ctrl_o.mem_op = MEM_SW;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.imm_type  = IMM_B;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = ALU_EQ;
                    3'b001:  ctrl_o.alu_op = ALU_NE;
                    3'b100:  ctrl_o.alu_op = ALU_LT;
                    3'b101:  ctrl_o.alu_op = ALU_GE;
                    3'b110:  ctrl_o.alu_op = ALU_LTU;
                    3'b111:  ctrl_o.alu_op = ALU_GEU;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                ctrl_o.rd_we    = 1'b1;
                ctrl_o.is_jal   = 1'b1;
                ctrl_o.op_a_sel = OPA_PC;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.imm_type = IMM_J;
            end
            OPC_JALR: begin
                ctrl_o.rd_we    = 1'b1;
                ctrl_o.is_jalr  = 1'b1;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.imm_type = IMM_I;
                ctrl_o.illegal  = (funct3 != 3'b000);
            end
            default: ctrl_o.illegal = 1'b1;   // unknown opcode
        endcase

        // illegal words must not write or touch memory or steer fetch
        if (ctrl_o.illegal) begin
            ctrl_o.rd_we     = 1'b0;
            ctrl_o.mem_op    = MEM_NONE;
            ctrl_o.is_branch = 1'b0;
            ctrl_o.is_jal    = 1'b0;
            ctrl_o.is_jalr   = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: id_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_imm_gen import id_pkg::*; (
    input  logic [31:0]         instr_i,
    input  imm_type_e           imm_type_i,
    output logic [`ID_XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];   // every format keeps its sign here

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            IMM_U: imm_o = {instr_i[31:12], 12'h000};
            IMM_J: imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
            default: imm_o = '0;   // no immediate
        endcase
    end

endmodule

`default_nettype wire

// File: id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [`ID_RIDX_W-1:0] rs1_idx_i,
    input  logic [`ID_RIDX_W-1:0] rs2_idx_i,
    output logic [`ID_XLEN-1:0]   rs1_data_o,
    output logic [`ID_XLEN-1:0]   rs2_data_o,
    input  wb_port_t              wb_i
);

    logic [`ID_XLEN-1:0] regs [`ID_NREGS-1:1];   // x0 not stored
    logic                wr_live;

    assign wr_live = wb_i.we && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < `ID_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through so decode sees this cycle's write-back
    always_comb begin
        if (rs1_idx_i == '0)                       rs1_data_o = '0;
        else if (wr_live && wb_i.rd == rs1_idx_i)  rs1_data_o = wb_i.data;
        else                                       rs1_data_o = regs[rs1_idx_i];

        if (rs2_idx_i == '0)                       rs2_data_o = '0;
        else if (wr_live && wb_i.rd == rs2_idx_i)  rs2_data_o = wb_i.data;
        else                                       rs2_data_o = regs[rs2_idx_i];
    end

endmodule

`default_nettype wire

// File: id_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_branch_predictor import id_pkg::*; (
    input  dec_ctrl_t           ctrl_i,
    input  logic [`ID_XLEN-1:0] pc_i,
    input  logic [`ID_XLEN-1:0] imm_i,
    input  logic [`ID_XLEN-1:0] rs1_data_i,
    input  logic                rs1_busy_i,
    output logic                taken_o,
    output logic [`ID_XLEN-1:0] target_o
);

    logic [`ID_XLEN-1:0] pc_rel;
    logic [`ID_XLEN-1:0] reg_rel;

    assign pc_rel  = pc_i + imm_i;
    assign reg_rel = (rs1_data_i + imm_i) & ~`ID_XLEN'(1);   // jalr drops bit 0

    always_comb begin
        taken_o  = 1'b0;
        target_o = pc_rel;
        if (ctrl_i.is_jal) begin
            taken_o = 1'b1;
        end else if (ctrl_i.is_branch) begin
            taken_o = imm_i[`ID_XLEN-1];   // backward taken, forward not
        end else if (ctrl_i.is_jalr) begin
            taken_o  = !rs1_busy_i;   // stale rs1, leave it to execute
            target_o = reg_rel;
        end
    end

endmodule

`default_nettype wire

// File: id_pc_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_pc_tracker import id_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic                enable_i,
    input  logic                flush_i,
    input  logic                pred_taken_i,
    input  logic [`ID_XLEN-1:0] pred_target_i,
    input  ex_redirect_t        ex_redirect_i,
    output logic [`ID_XLEN-1:0] pc_o,
    output ex_redirect_t        redirect_o
);

    logic [`ID_XLEN-1:0] pc_q;
    logic [`ID_XLEN-1:0] pc_seq;
    logic                advance;

    assign pc_seq  = pc_q + `ID_XLEN'(4);
    assign advance = enable_i || ex_redirect_i.valid;

    // ====================
    // redirect toward fetch
    // ====================
    always_comb begin
        if (ex_redirect_i.valid) begin
            redirect_o.valid = 1'b1;   // execute always wins
            redirect_o.pc    = ex_redirect_i.pc;
        end else begin
            redirect_o.valid = pred_taken_i;
            redirect_o.pc    = pred_target_i;
        end
    end

    // ====================
    // instruction pc
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn || flush_i) begin
            pc_q <= `ID_RESET_PC;
        end else if (advance) begin
            pc_q <= redirect_o.valid ? redirect_o.pc : pc_seq;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: id_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_pipe_reg import id_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  enable_i,
    input  logic                  flush_i,
    input  dec_ctrl_t             ctrl_i,
    input  logic [`ID_XLEN-1:0]   pc_i,
    input  logic [`ID_XLEN-1:0]   imm_i,
    input  logic [`ID_XLEN-1:0]   rs1_data_i,
    input  logic [`ID_XLEN-1:0]   rs2_data_i,
    input  logic [`ID_RIDX_W-1:0] rd_i,
    input  logic                  pred_taken_i,
    input  logic [`ID_XLEN-1:0]   pred_target_i,
    output id_ex_t                id_ex_o
);

    logic [`ID_XLEN-1:0] op_a;
    logic [`ID_XLEN-1:0] op_b;

    // operand muxes
    always_comb begin
        case (ctrl_i.op_a_sel)
            OPA_PC:   op_a = pc_i;          // auipc, jal
            OPA_ZERO: op_a = '0;            // lui
            default:  op_a = rs1_data_i;
        endcase
    end

    assign op_b = (ctrl_i.op_b_sel == OPB_IMM) ? imm_i : rs2_data_i;

    // ====================
    // decode to execute register
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn || flush_i) begin
            id_ex_o <= '0;
        end else if (enable_i) begin
            id_ex_o.valid      <= 1'b1;
            id_ex_o.alu_op     <= ctrl_i.alu_op;
            id_ex_o.op_a       <= op_a;
            id_ex_o.op_b       <= op_b;
            id_ex_o.rs2_val    <= rs2_data_i;
            id_ex_o.imm        <= imm_i;
            id_ex_o.rd         <= rd_i;
            id_ex_o.rd_we      <= ctrl_i.rd_we;
            id_ex_o.mem_op     <= ctrl_i.mem_op;
            id_ex_o.is_branch  <= ctrl_i.is_branch;
            id_ex_o.is_jalr    <= ctrl_i.is_jalr;
            id_ex_o.pred_taken <= pred_taken_i;
            id_ex_o.pred_pc    <= pred_target_i;
            id_ex_o.pc_next    <= pc_i + `ID_XLEN'(4);
            id_ex_o.illegal    <= ctrl_i.illegal;
        end
    end

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_stage import id_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  logic         enable_i,
    input  logic         flush_i,
    input  logic [31:0]  instr_i,
    input  wb_port_t     wb_i,
    input  ex_redirect_t ex_redirect_i,
    input  logic         rs1_busy_i,    // rs1 still in flight
    output ex_redirect_t redirect_o,
    output id_ex_t       id_ex_o
);

    dec_ctrl_t           ctrl;
    logic [`ID_XLEN-1:0] imm;
    logic [`ID_XLEN-1:0] rs1_data;
    logic [`ID_XLEN-1:0] rs2_data;
    logic [`ID_XLEN-1:0] pc;
    logic                pred_taken;
    logic [`ID_XLEN-1:0] pred_target;

    // ====================
    // decode
    // ====================
    id_decoder i_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    id_imm_gen i_imm_gen (
        .instr_i    (instr_i),
        .imm_type_i (ctrl.imm_type),
        .imm_o      (imm)
    );

    id_regfile i_regfile (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_idx_i  (instr_i[19:15]),
        .rs2_idx_i  (instr_i[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    // ====================
    // prediction and pc
    // ====================
    id_branch_predictor i_branch_predictor (
        .ctrl_i     (ctrl),
        .pc_i       (pc),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .rs1_busy_i (rs1_busy_i),
        .taken_o    (pred_taken),
        .target_o   (pred_target)
    );

    id_pc_tracker i_pc_tracker (
        .clk           (clk),
        .resetn        (resetn),
        .enable_i      (enable_i),
        .flush_i       (flush_i),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .ex_redirect_i (ex_redirect_i),
        .pc_o          (pc),
        .redirect_o    (redirect_o)
    );

    id_pipe_reg i_pipe_reg (
        .clk           (clk),
        .resetn        (resetn),
        .enable_i      (enable_i),
        .flush_i       (flush_i),
        .ctrl_i        (ctrl),
        .pc_i          (pc),
        .imm_i         (imm),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rd_i          (instr_i[11:7]),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .id_ex_o       (id_ex_o)
    );

endmodule

`default_nettype wire

// File: id_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_props import id_pkg::*; (
    input logic         clk,
    input logic         resetn,
    input logic         enable_i,
    input logic         flush_i,
    input ex_redirect_t ex_redirect_i,
    input ex_redirect_t redirect_o,
    input id_ex_t       id_ex_o
);

    // empty bundle right after reset or flush
    a_clear: assert property (@(posedge clk) (!resetn || flush_i) |=> !id_ex_o.valid)
        else $error("id_ex_o valid one cycle after reset or flush");

    a_ex_wins: assert property (@(posedge clk) disable iff (!resetn)
        ex_redirect_i.valid |-> redirect_o.valid)
        else $error("execute redirect not passed to fetch");

    a_aligned: assert property (@(posedge clk) disable iff (!resetn)
        redirect_o.valid |-> !redirect_o.pc[0])
        else $error("redirect pc has bit 0 set");

    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        (!enable_i && !flush_i && !ex_redirect_i.valid) |=> $stable(id_ex_o))
        else $error("id_ex_o changed during a stall");

endmodule

bind id_stage id_stage_props i_id_stage_props (
    .clk           (clk),
    .resetn        (resetn),
    .enable_i      (enable_i),
    .flush_i       (flush_i),
    .ex_redirect_i (ex_redirect_i),
    .redirect_o    (redirect_o),
    .id_ex_o       (id_ex_o)
);

`default_nettype wire

// File: tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module tb_id_stage import id_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 6;

    // base opcodes, straight from the isa tables
    localparam logic [6:0] OP_R     = 7'h33;
    localparam logic [6:0] OP_I     = 7'h13;
    localparam logic [6:0] OP_LD    = 7'h03;
    localparam logic [6:0] OP_ST    = 7'h23;
    localparam logic [6:0] OP_BR    = 7'h63;
    localparam logic [6:0] OP_JAL   = 7'h6f;
    localparam logic [6:0] OP_JALR  = 7'h67;
    localparam logic [6:0] OP_LUI   = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;

    logic         clk;
    logic         resetn;
    logic         enable;
    logic         flush;
    logic [31:0]  instr;
    wb_port_t     wb;
    ex_redirect_t ex_redir;
    logic         rs1_busy;
    ex_redirect_t redirect;
    id_ex_t       id_ex;

    integer      seed;
    int          checks;
    int          errors;
    int          checks_at;
    int          errors_at;
    int          test_no;
    logic [31:0] regs [0:31];   // model register file
    logic [31:0] exp_pc;
    id_ex_t      exp_ex;
    logic        exp_full;      // check every field, or only the illegal ones

    id_stage i_id_stage (
        .clk           (clk),
        .resetn        (resetn),
        .enable_i      (enable),
        .flush_i       (flush),
        .instr_i       (instr),
        .wb_i          (wb),
        .ex_redirect_i (ex_redir),
        .rs1_busy_i    (rs1_busy),
        .redirect_o    (redirect),
        .id_ex_o       (id_ex)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // reference model
    // ====================
    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0) return 32'd0;
        if (wb.we && wb.rd == idx) return wb.data;   // write-through
        return regs[idx];
    endfunction

    function automatic logic model_illegal(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OP_R:    return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            OP_I:    return (f3 == 3'd1 && f7 != 7'h00) ||
                            (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            OP_LD:   return f3 == 3'd3 || f3 > 3'd5;
            OP_ST:   return f3 > 3'd2;
            OP_BR:   return f3 == 3'd2 || f3 == 3'd3;
            OP_JALR: return f3 != 3'd0;
            OP_LUI, OP_AUIPC, OP_JAL: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] model_imm(input logic [31:0] w);
        case (w[6:0])
            OP_I, OP_LD, OP_JALR: return {{20{w[31]}}, w[31:20]};
            OP_ST:           return {{20{w[31]}}, w[31:25], w[11:7]};
            OP_BR:           return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OP_LUI, OP_AUIPC: return {w[31:12], 12'h000};
            OP_JAL:          return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:         return 32'd0;
        endcase
    endfunction

    function automatic alu_op_e model_alu(input logic [31:0] w);
        logic [6:0] opc;
        logic [2:0] f3;
        opc = w[6:0];
        f3  = w[14:12];
        if (opc == OP_BR) begin
            case (f3)
                3'd0:    return ALU_EQ;
                3'd1:    return ALU_NE;
                3'd4:    return ALU_LT;
                3'd5:    return ALU_GE;
                3'd6:    return ALU_LTU;
                default: return ALU_GEU;
            endcase
        end
        if (opc == OP_R || opc == OP_I) begin
            case (f3)
                3'd0:    return (opc == OP_R && w[30]) ? ALU_SUB : ALU_ADD;
                3'd1:    return ALU_SLL;
                3'd2:    return ALU_SLT;
                3'd3:    return ALU_SLTU;
                3'd4:    return ALU_XOR;
                3'd5:    return w[30] ? ALU_SRA : ALU_SRL;
                3'd6:    return ALU_OR;
                default: return ALU_AND;
            endcase
        end
        return ALU_ADD;   // address and link adds
    endfunction

    function automatic mem_op_e model_mem(input logic [31:0] w);
        if (w[6:0] == OP_LD) begin
            case (w[14:12])
                3'd0:    return MEM_LB;
                3'd1:    return MEM_LH;
                3'd2:    return MEM_LW;
                3'd4:    return MEM_LBU;
                3'd5:    return MEM_LHU;
                default: return MEM_NONE;
            endcase
        end else if (w[6:0] == OP_ST) begin
            case (w[14:12])
                3'd0:    return MEM_SB;
                3'd1:    return MEM_SH;
                3'd2:    return MEM_SW;
                default: return MEM_NONE;
            endcase
        end
        return MEM_NONE;
    endfunction

    // expected bundle for the word sitting in decode right now
    function automatic id_ex_t model_bundle(input logic [31:0] w, input logic busy);
        id_ex_t      e;
        logic [6:0]  opc;
        logic [31:0] rs1;
        opc       = w[6:0];
        rs1       = read_reg(w[19:15]);
        e         = '0;
        e.valid   = 1'b1;
        e.illegal = model_illegal(w);
        e.alu_op  = model_alu(w);
        e.imm     = model_imm(w);
        e.rd      = w[11:7];
        e.rs2_val = read_reg(w[24:20]);
        e.op_a    = (opc == OP_LUI) ? 32'd0 : (opc == OP_AUIPC || opc == OP_JAL) ? exp_pc : rs1;
        e.op_b    = (opc == OP_R || opc == OP_BR) ? e.rs2_val : e.imm;
        e.pc_next = exp_pc + 32'd4;
        e.pred_pc = exp_pc + e.imm;
        if (!e.illegal) begin
            e.rd_we     = !(opc == OP_ST || opc == OP_BR);
            e.mem_op    = model_mem(w);
            e.is_branch = (opc == OP_BR);
            e.is_jalr   = (opc == OP_JALR);
            if (opc == OP_JAL) begin
                e.pred_taken = 1'b1;
            end else if (opc == OP_BR) begin
                e.pred_taken = e.imm[31];   // backward only
            end else if (opc == OP_JALR) begin
                e.pred_taken = !busy;
                e.pred_pc    = (rs1 + e.imm) & ~32'd1;
            end
        end
        return e;
    endfunction

    // ====================
    // stimulus
    // ====================
    function automatic logic [31:0] gen_alu();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = $random(seed);
        f3 = r[14:12];
        f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[30], 5'b0} : 7'b0;
        case (r[1:0])
            2'd0:    return {f7, r[24:7], OP_R};
            2'd1:    return {(f3 == 3'd1 || f3 == 3'd5) ? f7 : r[31:25], r[24:7], OP_I};
            2'd2:    return {r[31:7], OP_LUI};
            default: return {r[31:7], OP_AUIPC};
        endcase
    endfunction

    function automatic logic [31:0] gen_mem();
        logic [31:0] r;
        r = $random(seed);
        if (r[0]) begin
            return {r[31:15], (r[2:1] == 2'd3) ? {2'b10, r[3]} : {1'b0, r[2:1]}, r[11:7], OP_LD};
        end
        return {r[31:15], (r[2:1] == 2'd3) ? 3'd2 : {1'b0, r[2:1]}, r[11:7], OP_ST};
    endfunction

    function automatic logic [31:0] gen_ctl();
        logic [31:0] r;
        logic [2:0]  f3;
        r  = $random(seed);
        f3 = {r[2], r[2] & r[1], r[3]};   // skips the two unused branch codes
        case (r[5:4])
            2'd2:    return {r[31:7], OP_JAL};
            2'd3:    return {r[31:15], 3'b000, r[11:7], OP_JALR};
            default: return {r[31:15], f3, r[11:7], OP_BR};
        endcase
    endfunction

    function automatic logic [31:0] gen_illegal();
        logic [31:0] r;
        r = $random(seed);
        case (r[9:7])   // real opcode most of the time, so bad funct fields get hit
            3'd0:    r[6:0] = OP_R;
            3'd1:    r[6:0] = OP_I;
            3'd2:    r[6:0] = OP_LD;
            3'd3:    r[6:0] = OP_ST;
            3'd4:    r[6:0] = OP_BR;
            3'd5:    r[6:0] = OP_JALR;
            default: ;
        endcase
        if (!model_illegal(r)) r[0] = 1'b0;   // no base opcode has bit 0 clear
        return r;
    endfunction

    function automatic wb_port_t gen_wb();
        wb_port_t    v;
        logic [31:0] r;
        r      = $random(seed);
        v.we   = r[0];
        v.rd   = r[5:1];
        v.data = $random(seed);
        return v;
    endfunction

    function automatic ex_redirect_t gen_exr(input logic valid);
        ex_redirect_t v;
        v.valid = valid;
        v.pc    = $random(seed) & ~32'd3;
        return v;
    endfunction

    // ====================
    // checking and driving
    // ====================
    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bundle();
        if (!exp_ex.valid) begin
            compare(32'(|id_ex), 32'd0, "id_ex not cleared");
        end else begin
            compare(id_ex.valid, 1'b1, "valid");
            compare(id_ex.illegal, exp_ex.illegal, "illegal");
            compare(id_ex.rd_we, exp_ex.rd_we, "rd_we");
            compare(id_ex.mem_op, exp_ex.mem_op, "mem_op");
            if (exp_full) begin
                compare(id_ex.alu_op, exp_ex.alu_op, "alu_op");
                compare(id_ex.op_a, exp_ex.op_a, "op_a");
                compare(id_ex.op_b, exp_ex.op_b, "op_b");
                compare(id_ex.rs2_val, exp_ex.rs2_val, "rs2_val");
                compare(id_ex.imm, exp_ex.imm, "imm");
                compare(id_ex.rd, exp_ex.rd, "rd");
                compare(id_ex.is_branch, exp_ex.is_branch, "is_branch");
                compare(id_ex.is_jalr, exp_ex.is_jalr, "is_jalr");
                compare(id_ex.pred_taken, exp_ex.pred_taken, "pred_taken");
                if (exp_ex.pred_taken) compare(id_ex.pred_pc, exp_ex.pred_pc, "pred_pc");
                compare(id_ex.pc_next, exp_ex.pc_next, "pc_next");
            end
        end
    endtask

    // entered on a falling edge, returns on the next one
    task automatic run_cycle(input logic [31:0] w, input logic en, input logic fl,
                             input ex_redirect_t exr, input logic busy, input wb_port_t wbv,
                             input logic full);
        id_ex_t       e;
        ex_redirect_t r;
        instr    = w;
        enable   = en;
        flush    = fl;
        ex_redir = exr;
        rs1_busy = busy;
        wb       = wbv;
        #1;
        e       = model_bundle(w, busy);
        r.valid = exr.valid || e.pred_taken;
        r.pc    = exr.valid ? exr.pc : e.pred_pc;
        compare(redirect.valid, r.valid, "redirect valid");
        if (r.valid) compare(redirect.pc, r.pc, "redirect pc");
        // model state after the coming edge
        if (fl) begin
            exp_ex = '0;
            exp_pc = `ID_RESET_PC;
        end else begin
            if (en) begin
                exp_ex   = e;
                exp_full = full;
            end
            if (en || exr.valid) exp_pc = r.valid ? r.pc : exp_pc + 32'd4;
        end
        if (wbv.we && wbv.rd != 5'd0) regs[wbv.rd] = wbv.data;
        @(negedge clk);
        check_bundle();
    endtask

    task automatic apply_reset(input int cycles);
        resetn   = 1'b0;
        enable   = 1'b0;
        flush    = 1'b0;
        instr    = {25'd0, OP_I};   // nop
        wb       = '0;
        ex_redir = '0;
        rs1_busy = 1'b0;
        repeat (cycles) @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        exp_pc   = `ID_RESET_PC;
        exp_ex   = '0;
        exp_full = 1'b1;
        check_bundle();
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s done: %0d checks, %0d errors", test_no, name,
                 checks - checks_at, errors - errors_at);
        test_no++;
        checks_at = checks;
        errors_at = errors;
    endtask

    // ====================
    // watchdog and main sequence
    // ====================
    initial begin
        #((NUM_TESTS * 300 + 100) * CLK_PERIOD);
        $display("ERROR: run timed out before all tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0]  w;
        logic [31:0]  r;
        wb_port_t     wbv;
        ex_redirect_t exr;
        clk       = 1'b0;
        seed      = 32'h74c0751d;
        checks    = 0;
        errors    = 0;
        checks_at = 0;
        errors_at = 0;
        test_no   = 1;
        apply_reset(4);

        for (int i = 0; i < 60; i++) begin
            w   = gen_alu();
            wbv = gen_wb();
            run_cycle(w, 1'b1, 1'b0, '0, 1'b0, wbv, 1'b1);
        end
        end_test("alu decode");

        for (int i = 0; i < 80; i++) begin
            r = $random(seed);
            w = {7'b0, r[24:20], r[19:15], 3'b000, r[11:7], OP_R};
            if (r[1:0] == 2'd1) w[19:15] = 5'd0;   // x0 read
            wbv.we   = r[31];
            wbv.rd   = (r[1:0] < 2'd2) ? w[19:15] : r[29:25];   // same-cycle hit or x0
            wbv.data = $random(seed);
            run_cycle(w, 1'b1, 1'b0, '0, 1'b0, wbv, 1'b1);
        end
        end_test("write-back and read-back");

        for (int i = 0; i < 60; i++) begin
            w   = gen_mem();
            wbv = gen_wb();
            run_cycle(w, 1'b1, 1'b0, '0, 1'b0, wbv, 1'b1);
        end
        end_test("loads and stores");

        for (int i = 0; i < 80; i++) begin
            r   = $random(seed);
            w   = gen_ctl();
            wbv = gen_wb();
            exr = gen_exr(r[1:0] == 2'd0);
            run_cycle(w, 1'b1, 1'b0, exr, r[2], wbv, 1'b1);
        end
        end_test("prediction and redirect");

        for (int i = 0; i < 40; i++) begin
            r   = $random(seed);
            w   = gen_alu();
            exr = gen_exr(r[5:4] == 2'd0);
            run_cycle(w, r[0], r[3:1] == 3'd0, exr, 1'b0, '0, 1'b1);   // mostly stalls
        end
        apply_reset(2);
        end_test("stall, flush and reset");

        for (int i = 0; i < 40; i++) begin
            w   = gen_illegal();
            wbv = gen_wb();
            run_cycle(w, 1'b1, 1'b0, '0, 1'b0, wbv, 1'b0);
        end
        end_test("illegal instructions");

        $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
id_pkg.sv
id_decoder.sv
id_imm_gen.sv
id_regfile.sv
id_branch_predictor.sv
id_pc_tracker.sv
id_pipe_reg.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

export_include_dirs:
  - .

sources:
  - files:
      - id_pkg.sv
      - id_decoder.sv
      - id_imm_gen.sv
      - id_regfile.sv
      - id_branch_predictor.sv
      - id_pc_tracker.sv
      - id_pipe_reg.sv
      - id_stage.sv
  - target: test
    files:
      - id_stage_props.sv
      - tb_id_stage.sv
